//--- common/cmd_pkg.sv
// Host command codes and register map; status and config addresses share the 8-bit space
package cmd_pkg;

  typedef logic [63:0] word_t;
  typedef logic [7:0] header_t;
  typedef logic [7:0] reg_addr_t;

  // Command code in header bits 63:56
  typedef enum logic [7:0] {
    cmd_idle   = 8'h00,
    cmd_move   = 8'h01,
    cmd_status = 8'hf1,
    cmd_config = 8'hf2
  } cmd_e;

  localparam reg_addr_t status_version      = 8'd0;
  localparam reg_addr_t status_channel_info = 8'd1;

  localparam reg_addr_t config_enable = 8'd0;
  localparam reg_addr_t config_clocks = 8'd1;

  localparam logic [7:0] default_clock_divisor = 8'd32;

  localparam logic [7:0] version_patch = 8'd1;
  localparam logic [7:0] version_minor = 8'd2;
  localparam logic [7:0] version_major = 8'd0;
  localparam logic [7:0] version_devel = 8'd0;

  localparam word_t version_word = {32'd0, version_devel, version_major, version_minor,
                                    version_patch};

endpackage

//--- common/motion_pkg.sv
// Motion sizes and types; buffer_size and num_motors must be powers of two
package motion_pkg;

  localparam int num_motors     = 2;
  localparam int buffer_size    = 2;
  localparam int dda_width      = 64;
  localparam int duration_width = 32;

  typedef logic [dda_width-1:0] dda_t;            // Wraps modulo 2^64
  typedef logic [duration_width-1:0] duration_t;  // Move length in DDA ticks
  typedef logic [num_motors-1:0] motor_mask_t;
  typedef logic [$clog2(buffer_size)-1:0] slot_t;
  typedef logic [$clog2(num_motors)-1:0] motor_t;
  typedef logic [7:0] divisor_t;

  // Sequencer states
  typedef enum logic [1:0] {
    seq_idle,
    seq_load,
    seq_run
  } seq_state_e;

endpackage

//--- rtl/clock_divider.sv
// One-cycle tick every divisor clocks; divisor values below 2 are not supported
`timescale 1ns/1ps

module clock_divider (
  input  logic                  CLK,
  input  logic                  resetn,
  input  motion_pkg::divisor_t  divisor,
  output logic                  dda_tick
);

  motion_pkg::divisor_t count;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      count    <= '0;
      dda_tick <= 1'b0;
    end else if (count <= motion_pkg::divisor_t'(1)) begin
      count    <= divisor;  // New divisor takes effect here
      dda_tick <= 1'b1;
    end else begin
      count    <= count - motion_pkg::divisor_t'(1);
      dda_tick <= 1'b0;
    end
  end

endmodule

//--- motion/dda_timer.sv
// Step level is accumulator bit 63; increment values are expected to stay well below 2^63
`timescale 1ns/1ps

module dda_timer (
  input  logic              CLK,
  input  logic              resetn,
  input  logic              dda_tick,
  input  logic              load,
  input  logic              run,
  input  motion_pkg::dda_t  increment,
  input  motion_pkg::dda_t  incinc,
  output logic              step_level
);

  motion_pkg::dda_t accum;
  motion_pkg::dda_t velocity;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      accum <= '0;
    end else if (load) begin
      accum <= '0;
    end else if (run && dda_tick) begin
      accum <= accum + velocity;  // Wraps
    end
  end

  // Velocity ramps by incinc per tick
  always_ff @(posedge CLK) begin
    if (load) begin
      velocity <= increment;
    end else if (run && dda_tick) begin
      velocity <= velocity + incinc;
    end
  end

  assign step_level = accum[motion_pkg::dda_width-1];

endmodule

//--- motion/move_buffer.sv
// Ring of buffer_size move slots; a full ring drops buffer_dtr and must not be written
`timescale 1ns/1ps

module move_buffer (
  input  logic                     CLK,
  input  logic                     resetn,
  input  logic                     wr_dir,
  input  logic                     wr_duration,
  input  logic                     wr_inc,
  input  logic                     wr_incinc,
  input  motion_pkg::motor_t       wr_motor,
  input  logic                     commit,
  input  cmd_pkg::word_t           buf_data,
  input  logic                     slot_release,
  output logic                     buffer_dtr,
  output logic                     slot_ready,
  output motion_pkg::duration_t    duration,
  output motion_pkg::motor_mask_t  dir,
  output motion_pkg::dda_t         increment_0,
  output motion_pkg::dda_t         incinc_0,
  output motion_pkg::dda_t         increment_1,
  output motion_pkg::dda_t         incinc_1
);

  motion_pkg::motor_mask_t dir_mem [motion_pkg::buffer_size];
  motion_pkg::duration_t   dur_mem [motion_pkg::buffer_size];
  motion_pkg::dda_t        inc_mem [motion_pkg::buffer_size][motion_pkg::num_motors];
  motion_pkg::dda_t        incinc_mem [motion_pkg::buffer_size][motion_pkg::num_motors];
  logic [motion_pkg::buffer_size-1:0] ready;
  motion_pkg::slot_t wr_idx, rd_idx;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      ready  <= '0;
      wr_idx <= '0;
      rd_idx <= '0;
      for (int i = 0; i < motion_pkg::buffer_size; i++) dir_mem[i] <= '0;  // dir idles low
    end else begin
      if (wr_dir) dir_mem[wr_idx] <= buf_data[motion_pkg::num_motors-1:0];
      if (commit) begin
        ready[wr_idx] <= 1'b1;
        wr_idx        <= wr_idx + 1'b1;
      end
      if (slot_release) begin
        ready[rd_idx] <= 1'b0;
        rd_idx        <= rd_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (wr_duration) dur_mem[wr_idx] <= buf_data[motion_pkg::duration_width-1:0];
    if (wr_inc) inc_mem[wr_idx][wr_motor] <= buf_data;
    if (wr_incinc) incinc_mem[wr_idx][wr_motor] <= buf_data;
  end

  assign buffer_dtr  = ~ready[wr_idx];
  assign slot_ready  = ready[rd_idx];
  assign duration    = dur_mem[rd_idx];
  assign dir         = dir_mem[rd_idx];
  assign increment_0 = inc_mem[rd_idx][0];
  assign incinc_0    = incinc_mem[rd_idx][0];
  assign increment_1 = inc_mem[rd_idx][1];
  assign incinc_1    = incinc_mem[rd_idx][1];

  a_commit_free_slot: assert property (@(posedge CLK) disable iff (!resetn)
    commit |-> !ready[wr_idx]);

endmodule

//--- motion/move_sequencer.sv
// Runs one buffered move at a time; a duration of 0 runs as a single tick
`timescale 1ns/1ps

module move_sequencer (
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic                   dda_tick,
  input  logic                   slot_ready,
  input  motion_pkg::duration_t  duration,
  output logic                   load,
  output logic                   run,
  output logic                   move_done,
  output logic                   slot_release
);

  motion_pkg::seq_state_e state;
  motion_pkg::duration_t remaining;  // Ticks left in the move
  logic done_q;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state     <= motion_pkg::seq_idle;
      remaining <= '0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        motion_pkg::seq_idle: begin
          // Old slot still flagged during release
          if (slot_ready && !done_q) state <= motion_pkg::seq_load;
        end
        motion_pkg::seq_load: begin
          remaining <= duration;
          state     <= motion_pkg::seq_run;
        end
        motion_pkg::seq_run: begin
          if (dda_tick) begin
            remaining <= remaining - motion_pkg::duration_t'(1);
            if (remaining <= motion_pkg::duration_t'(1)) begin
              state  <= motion_pkg::seq_idle;
              done_q <= 1'b1;
            end
          end
        end
        default: state <= motion_pkg::seq_idle;
      endcase
    end
  end

  assign load         = (state == motion_pkg::seq_load);
  assign run          = (state == motion_pkg::seq_run);
  assign move_done    = done_q;
  assign slot_release = done_q;

  // Release only right after the last run cycle
  a_release_after_run: assert property (@(posedge CLK) disable iff (!resetn)
    slot_release |-> ($past(run) && !run));

endmodule

//--- host_link/command_decoder.sv
// Host words must stay stable while word_received is high; moves only while buffer_dtr is high
`timescale 1ns/1ps

module command_decoder (
  input  logic                     CLK,
  input  logic                     resetn,
  input  cmd_pkg::word_t           word_data_received,
  input  logic                     word_received,
  input  logic                     slot_full,
  output cmd_pkg::word_t           word_send_data,
  output logic                     wr_dir,
  output logic                     wr_duration,
  output logic                     wr_inc,
  output logic                     wr_incinc,
  output motion_pkg::motor_t       wr_motor,
  output logic                     commit,
  output cmd_pkg::word_t           buf_data,
  output motion_pkg::motor_mask_t  enable,
  output motion_pkg::divisor_t     divisor
);

  logic strobe_q, strobe_qq;
  logic rise;
  cmd_pkg::cmd_e state;         // Header of the message in progress
  logic [3:0] word_cnt;         // Words after the header
  logic [3:0] move_idx;
  cmd_pkg::header_t hdr;
  cmd_pkg::reg_addr_t hdr_addr;
  cmd_pkg::reg_addr_t cfg_addr;
  cmd_pkg::word_t status_value, config_value;

  assign rise     = strobe_q & ~strobe_qq;
  assign hdr      = word_data_received[63:56];
  assign hdr_addr = word_data_received[7:0];
  assign move_idx = word_cnt - 4'd1;

  always_comb begin
    case (hdr_addr)
      cmd_pkg::status_version:      status_value = cmd_pkg::version_word;
      cmd_pkg::status_channel_info: status_value = {32'd0, 8'(motion_pkg::duration_width),
                                                    8'(motion_pkg::dda_width), 8'd0,
                                                    8'(motion_pkg::num_motors)};
      default:                      status_value = '0;
    endcase
    case (hdr_addr)
      cmd_pkg::config_enable: config_value = cmd_pkg::word_t'(enable);
      cmd_pkg::config_clocks: config_value = cmd_pkg::word_t'(divisor);
      default:                config_value = '0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      strobe_q       <= 1'b0;
      strobe_qq      <= 1'b0;
      state          <= cmd_pkg::cmd_idle;
      word_cnt       <= '0;
      word_send_data <= '0;
      wr_dir         <= 1'b0;
      wr_duration    <= 1'b0;
      wr_inc         <= 1'b0;
      wr_incinc      <= 1'b0;
      commit         <= 1'b0;
      enable         <= '0;
      divisor        <= cmd_pkg::default_clock_divisor;
    end else begin
      strobe_q    <= word_received;
      strobe_qq   <= strobe_q;
      wr_dir      <= 1'b0;  // Strobes last one cycle
      wr_duration <= 1'b0;
      wr_inc      <= 1'b0;
      wr_incinc   <= 1'b0;
      commit      <= 1'b0;
      if (rise) begin
        word_send_data <= '0;
        case (state)
          cmd_pkg::cmd_idle: begin
            word_cnt <= '0;
            case (hdr)
              cmd_pkg::cmd_move: begin
                wr_dir <= 1'b1;
                state  <= cmd_pkg::cmd_move;
              end
              cmd_pkg::cmd_status: begin
                word_send_data <= status_value;
                state          <= cmd_pkg::cmd_status;
              end
              cmd_pkg::cmd_config: begin
                word_send_data <= config_value;  // Old value goes back
                state          <= cmd_pkg::cmd_config;
              end
              default: state <= cmd_pkg::cmd_idle;
            endcase
          end
          cmd_pkg::cmd_move: begin
            word_cnt <= word_cnt + 4'd1;
            if (word_cnt == 4'd0) begin
              wr_duration <= 1'b1;
            end else begin
              wr_inc    <= ~move_idx[0];
              wr_incinc <= move_idx[0];
            end
            // Last incinc word commits the slot
            if (word_cnt == 4'(2 * motion_pkg::num_motors)) begin
              commit <= 1'b1;
              state  <= cmd_pkg::cmd_idle;
            end
          end
          cmd_pkg::cmd_config: begin
            if (cfg_addr == cmd_pkg::config_enable) begin
              enable <= word_data_received[motion_pkg::num_motors-1:0];
            end else if (cfg_addr == cmd_pkg::config_clocks) begin
              divisor <= word_data_received[7:0];
            end
            state <= cmd_pkg::cmd_idle;
          end
          default: state <= cmd_pkg::cmd_idle;  // Status data word is dropped
        endcase
      end
    end
  end

  // Payload registers
  always_ff @(posedge CLK) begin
    if (rise) begin
      buf_data <= word_data_received;
      wr_motor <= motion_pkg::motor_t'(move_idx >> 1);
      if (state == cmd_pkg::cmd_idle) cfg_addr <= hdr_addr;
    end
  end

  // Host honours buffer_dtr before a move header
  a_no_move_when_full: assert property (@(posedge CLK) disable iff (!resetn)
    (rise && state == cmd_pkg::cmd_idle && hdr == cmd_pkg::cmd_move) |-> !slot_full);

endmodule

//--- rtl/stepper_controller_top.sv
// Two-axis step generator; host must wait for buffer_dtr before sending a move
`timescale 1ns/1ps

module stepper_controller_top (
  input  logic                     CLK,
  input  logic                     resetn,
  input  cmd_pkg::word_t           word_data_received,
  input  logic                     word_received,
  output cmd_pkg::word_t           word_send_data,
  output logic                     buffer_dtr,
  output logic                     move_done,
  output motion_pkg::motor_mask_t  step,
  output motion_pkg::motor_mask_t  dir
);

  logic wr_dir, wr_duration, wr_inc, wr_incinc, commit;
  motion_pkg::motor_t wr_motor;
  cmd_pkg::word_t buf_data;
  motion_pkg::motor_mask_t enable;
  motion_pkg::divisor_t divisor;
  logic slot_ready, slot_release, load, run, dda_tick;
  motion_pkg::duration_t duration;
  motion_pkg::dda_t inc_w [motion_pkg::num_motors];
  motion_pkg::dda_t incinc_w [motion_pkg::num_motors];
  motion_pkg::motor_mask_t step_level;

  command_decoder u_decoder (
    .CLK, .resetn, .word_data_received, .word_received,
    .slot_full (~buffer_dtr),
    .word_send_data, .wr_dir, .wr_duration, .wr_inc, .wr_incinc, .wr_motor,
    .commit, .buf_data, .enable, .divisor
  );

  move_buffer u_buffer (
    .CLK, .resetn, .wr_dir, .wr_duration, .wr_inc, .wr_incinc, .wr_motor,
    .commit, .buf_data, .slot_release, .buffer_dtr, .slot_ready, .duration, .dir,
    .increment_0 (inc_w[0]), .incinc_0 (incinc_w[0]),
    .increment_1 (inc_w[1]), .incinc_1 (incinc_w[1])
  );

  move_sequencer u_sequencer (
    .CLK, .resetn, .dda_tick, .slot_ready, .duration, .load, .run, .move_done,
    .slot_release
  );

  clock_divider u_divider (.CLK, .resetn, .divisor, .dda_tick);

  // One DDA timer per motor
  for (genvar m = 0; m < motion_pkg::num_motors; m++) begin : g_timer
    dda_timer u_timer (
      .CLK, .resetn, .dda_tick, .load, .run,
      .increment (inc_w[m]), .incinc (incinc_w[m]), .step_level (step_level[m])
    );
  end

  assign step = step_level & enable;  // Disabled motors stay quiet

endmodule

//--- dv/tb_stepper_controller.sv
// Host model drives words on the falling edge; increments stay below 2^59, divisor stays >= 2
`timescale 1ns/1ps

module tb_stepper_controller;

  typedef struct {
    cmd_pkg::header_t        cmd;
    logic [7:0]              arg;       // Register address or dir
    cmd_pkg::word_t          wdata;     // Word after a status or config header
    motion_pkg::duration_t   dur;
    motion_pkg::motor_mask_t en;        // Enable in force during the move
    motion_pkg::divisor_t    div;       // Divisor in force during the move
    cmd_pkg::word_t          reply;
    logic                    wait_done;
    logic                    dtr_low;   // Buffer full right after this row
    logic                    ref_time;
    logic                    faster;    // Must beat the reference move
  } row_t;

  localparam int num_rows = 15;
  localparam cmd_pkg::header_t mv = cmd_pkg::cmd_move;
  localparam cmd_pkg::header_t st = cmd_pkg::cmd_status;
  localparam cmd_pkg::header_t cf = cmd_pkg::cmd_config;

  logic CLK, resetn, word_received, buffer_dtr, move_done;
  cmd_pkg::word_t word_data_received, word_send_data;
  motion_pkg::motor_mask_t step, dir, step_q;
  row_t rows [num_rows];
  logic [15:0] lfsr;
  int cycle, ref_cycles;
  int edges [motion_pkg::num_motors];
  int res_cnt0[$], res_cnt1[$], res_cycle[$], exp_cnt0[$], exp_cnt1[$], start_cycle[$];
  motion_pkg::motor_mask_t res_dir[$], exp_dir[$];

  stepper_controller_top uut (
    .CLK (CLK), .resetn (resetn), .word_data_received (word_data_received),
    .word_received (word_received), .word_send_data (word_send_data),
    .buffer_dtr (buffer_dtr), .move_done (move_done), .step (step), .dir (dir)
  );

  always #20 CLK = ~CLK;

  always @(posedge CLK) cycle = cycle + 1;

  // Counts step rises; each move_done closes one move's record
  always @(negedge CLK) begin
    if (resetn) begin
      for (int m = 0; m < motion_pkg::num_motors; m++)
        if (step[m] && !step_q[m]) edges[m] = edges[m] + 1;
      if (move_done) begin
        res_cnt0.push_back(edges[0]);
        res_cnt1.push_back(edges[1]);
        res_dir.push_back(dir);
        res_cycle.push_back(cycle);
        edges[0] = 0;
        edges[1] = 0;
      end
    end
    step_q = step;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_word(input cmd_pkg::word_t got, input cmd_pkg::word_t exp,
                            input string what);
    if (got !== exp)
      stop_with_failure($sformatf("FAIL %0d ns: %s expected %h, got %h", $time, what, exp, got));
  endtask

  task automatic check_mask(input motion_pkg::motor_mask_t got,
                            input motion_pkg::motor_mask_t exp, input string what);
    if (got !== exp)
      stop_with_failure($sformatf("FAIL %0d ns: %s expected %b, got %b", $time, what, exp, got));
  endtask

  task automatic check_int(input int got, input int exp, input string what);
    if (got != exp)
      stop_with_failure($sformatf("FAIL %0d ns: %s expected %0d, got %0d", $time, what, exp,
                                  got));
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic motion_pkg::dda_t take_bits(input int n);
    motion_pkg::dda_t v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v = {v[62:0], fb};
    end
    return v;
  endfunction

  // Rises of accumulator bit 63 over one move
  function automatic int model_steps(input motion_pkg::dda_t inc, input motion_pkg::dda_t incinc,
                                     input motion_pkg::duration_t dur);
    motion_pkg::dda_t accum, vel;
    logic prev;
    int cnt;
    accum = '0;
    vel = inc;
    prev = 1'b0;
    cnt = 0;
    for (int t = 0; t < int'(dur); t++) begin
      accum = accum + vel;
      vel = vel + incinc;
      if (accum[63] && !prev) cnt++;
      prev = accum[63];
    end
    return cnt;
  endfunction

  task automatic fill_table();
    rows[0]  = '{st, 8'd0, '0, 32'd0, 2'b00, 8'd32, 64'h201, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[1]  = '{st, 8'd1, '0, 32'd0, 2'b00, 8'd32, 64'h2040_0002, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[2]  = '{st, 8'd7, '0, 32'd0, 2'b00, 8'd32, '0, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[3]  = '{cf, 8'd0, 64'd0, 32'd0, 2'b00, 8'd32, 64'd0, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[4]  = '{cf, 8'd1, 64'd32, 32'd0, 2'b00, 8'd32, 64'd32, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[5]  = '{cf, 8'd0, 64'd3, 32'd0, 2'b00, 8'd32, 64'd0, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[6]  = '{cf, 8'd0, 64'd3, 32'd0, 2'b00, 8'd32, 64'd3, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[7]  = '{mv, 8'h02, '0, 32'd48, 2'b11, 8'd32, '0, 1'b1, 1'b0, 1'b1, 1'b0};
    rows[8]  = '{cf, 8'd0, 64'd1, 32'd0, 2'b01, 8'd32, 64'd3, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[9]  = '{mv, 8'h01, '0, 32'd48, 2'b01, 8'd32, '0, 1'b1, 1'b0, 1'b0, 1'b0};
    rows[10] = '{cf, 8'd0, 64'd3, 32'd0, 2'b11, 8'd32, 64'd1, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[11] = '{mv, 8'h03, '0, 32'd40, 2'b11, 8'd32, '0, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[12] = '{mv, 8'h00, '0, 32'd40, 2'b11, 8'd32, '0, 1'b1, 1'b1, 1'b0, 1'b0};
    rows[13] = '{cf, 8'd1, 64'd8, 32'd0, 2'b11, 8'd8, 64'd32, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[14] = '{mv, 8'h02, '0, 32'd48, 2'b11, 8'd8, '0, 1'b1, 1'b0, 1'b0, 1'b1};
  endtask

  task automatic watchdog();
    longint limit_ns;
    limit_ns = 0;
    for (int i = 0; i < num_rows; i++)
      limit_ns = limit_ns + longint'(rows[i].dur) * longint'(rows[i].div);
    limit_ns = limit_ns * 40 * 4 + longint'(num_rows) * 4000 + 20000;  // Message traffic and reset
    #(limit_ns);
    stop_with_failure("Timeout: the tests did not finish within the time limit");
  endtask

  task automatic send_word(input cmd_pkg::word_t w, output cmd_pkg::word_t reply);
    @(negedge CLK);
    word_data_received = w;
    word_received = 1'b1;
    repeat (4) @(negedge CLK);
    word_received = 1'b0;
    repeat (4) @(negedge CLK);
    reply = word_send_data;
  endtask

  task automatic compare_move(input row_t r);
    int elapsed;
    elapsed = res_cycle.pop_front() - start_cycle.pop_front();
    check_int(res_cnt0.pop_front(), exp_cnt0.pop_front(), "step rises of motor 0");
    check_int(res_cnt1.pop_front(), exp_cnt1.pop_front(), "step rises of motor 1");
    check_mask(res_dir.pop_front(), exp_dir.pop_front(), "dir during move");
    if (r.ref_time) ref_cycles = elapsed;
    if (r.faster && elapsed >= ref_cycles)
      stop_with_failure($sformatf("FAIL %0d ns: move at divisor 8 took %0d cycles, not under %0d",
                                  $time, elapsed, ref_cycles));
  endtask

  task automatic apply_row(input row_t r);
    cmd_pkg::word_t reply;
    motion_pkg::dda_t inc, incinc;
    int cnt [motion_pkg::num_motors];
    if (r.cmd == mv) begin
      while (!buffer_dtr) @(negedge CLK);  // Host waits for a free slot
      if (exp_cnt0.size() == 0) begin
        edges[0] = 0;
        edges[1] = 0;
      end
      start_cycle.push_back(cycle);
      send_word({r.cmd, 48'd0, r.arg}, reply);
      check_word(reply, '0, "move header reply");
      send_word(cmd_pkg::word_t'(r.dur), reply);
      check_word(reply, '0, "duration reply");
      for (int m = 0; m < motion_pkg::num_motors; m++) begin
        inc = take_bits(59);
        incinc = take_bits(55);
        cnt[m] = r.en[m] ? model_steps(inc, incinc, r.dur) : 0;
        send_word(inc, reply);
        check_word(reply, '0, "increment reply");
        send_word(incinc, reply);
        check_word(reply, '0, "increment-increment reply");
      end
      exp_cnt0.push_back(cnt[0]);
      exp_cnt1.push_back(cnt[1]);
      exp_dir.push_back(r.arg[1:0]);
    end else begin
      send_word({r.cmd, 48'd0, r.arg}, reply);
      check_word(reply, r.reply, "header reply");
      send_word(r.wdata, reply);
      check_word(reply, '0, "data word reply");
    end
    if (r.dtr_low) begin
      check_int(int'(buffer_dtr), 0, "buffer_dtr after second commit");
      while (res_cnt0.size() < exp_cnt0.size() - 1) @(negedge CLK);
      repeat (2) @(negedge CLK);
      check_int(int'(buffer_dtr), 1, "buffer_dtr after first move_done");
    end
    if (r.wait_done) begin
      while (res_cnt0.size() < exp_cnt0.size()) @(negedge CLK);
      repeat (4) @(negedge CLK);
      check_int(res_cnt0.size(), exp_cnt0.size(), "move_done pulse count");
      while (exp_cnt0.size() > 0) compare_move(r);
    end
  endtask

  initial begin
    CLK = 1'b0;
    resetn = 1'b0;
    word_data_received = '0;
    word_received = 1'b0;
    cycle = 0;
    ref_cycles = 0;
    edges[0] = 0;
    edges[1] = 0;
    step_q = '0;
    lfsr = 16'd44834;
    fill_table();
    fork
      watchdog();
    join_none
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    resetn = 1'b1;
    check_word(word_send_data, '0, "word_send_data after reset");
    check_mask(dir, '0, "dir after reset");
    check_mask(step, '0, "step after reset");
    check_int(int'(buffer_dtr), 1, "buffer_dtr after reset");
    check_int(int'(move_done), 0, "move_done after reset");
    for (int i = 0; i < num_rows; i++) apply_row(rows[i]);
    check_int(res_cnt0.size(), 0, "extra move_done pulses");
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- verilog.f
common/cmd_pkg.sv
common/motion_pkg.sv
rtl/clock_divider.sv
motion/dda_timer.sv
motion/move_buffer.sv
motion/move_sequencer.sv
host_link/command_decoder.sv
rtl/stepper_controller_top.sv
dv/tb_stepper_controller.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_stepper_controller \
  -o tb_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
grep -q "STATUS: PASS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
